// File: bench/pacman_game_tb.sv
`timescale 1ns/100ps
`include "pacman_params.svh"

module pacman_game_tb;

	localparam int TICKS = 8;
	localparam int NUM_PHASES = 8;
	localparam int FILL_WAIT = 40;

	// one test phase; keys are active low, 4'hf means no key
	typedef struct packed {
		logic [3:0]  keys;
		logic        start;
		logic        rst;
		logic [7:0]  steps;
		logic [5:0]  ex;
		logic [4:0]  ey;
		logic [10:0] pills;
		logic        playing;
		logic        won;
	} phase_t;

	logic CLOCK_50;
	logic game_reset;
	logic [3:0] key;
	logic start;
	logic [4:0] row_addr;
	pacman_pkg::maze_row_u row_data;
	pacman_pkg::coord_t pac_pos;
	logic [10:0] pills_left;
	logic playing;
	logic won;

	phase_t phases [0:NUM_PHASES-1];
	logic [3:0] model [0:`MAZE_ROWS-1][0:`MAZE_COLS-1];
	int mx;
	int my;
	int mpills;
	logic [3:0] mdir;
	logic model_playing;
	int cyc;
	int value_errors;
	int other_errors;
	int cycle_limit;
	int wd_cycles;

	pacman_game #(.TICKS(TICKS)) pacman_game_i (.CLOCK_50(CLOCK_50), .game_reset(game_reset),
		.key(key), .start(start), .row_addr(row_addr), .row_data(row_data),
		.pac_pos(pac_pos), .pills_left(pills_left), .playing(playing), .won(won));

	initial begin
		CLOCK_50 = 1'b0;
		forever #10 CLOCK_50 = ~CLOCK_50;
	end

	task automatic tick();
		@(negedge CLOCK_50);
		cyc++;
	endtask

	task automatic set_phase(input int i, input logic [3:0] k, input logic s, input logic r,
		input int n, input int x, input int y, input int p, input logic pl, input logic w);
		phases[i] = '{keys: k, start: s, rst: r, steps: 8'(n), ex: 6'(x), ey: 5'(y),
			pills: 11'(p), playing: pl, won: w};
	endtask

	// fresh maze straight from the fill rule
	task automatic model_reset();
		for (int r = 0; r < `MAZE_ROWS; r++) begin
			for (int c = 0; c < `MAZE_COLS; c++) begin
				if (r == 0 || r == `MAZE_ROWS - 1 || c == 0 || c == `MAZE_COLS - 1)
					model[r][c] = 4'(pacman_pkg::wall);
				else if (r == `START_Y)
					model[r][c] = (c == `START_X) ? 4'(pacman_pkg::pacman) : 4'(pacman_pkg::pill);
				else
					model[r][c] = 4'(pacman_pkg::empty);
			end
		end
		mx = `START_X;
		my = `START_Y;
		mpills = `INIT_PILLS;
		mdir = 4'b0000;
		model_playing = 1'b0;
	endtask

	// one move of the reference model, bit 3 up, 2 down, 1 left, 0 right
	task automatic model_step();
		int tx;
		int ty;
		tx = mx;
		ty = my;
		if (mpills == 0 || mdir == 4'b0000) return;
		if (mdir[3]) ty = my - 1;
		else if (mdir[2]) ty = my + 1;
		else if (mdir[1]) tx = mx - 1;
		else tx = mx + 1;
		if (model[ty][tx] == 4'(pacman_pkg::wall)) return;
		if (model[ty][tx] == 4'(pacman_pkg::pill)) mpills--;
		model[ty][tx] = 4'(pacman_pkg::pacman);
		model[my][mx] = 4'(pacman_pkg::empty);
		mx = tx;
		my = ty;
	endtask

	function automatic logic [`ROW_BITS-1:0] expected_row(input int r);
		logic [`ROW_BITS-1:0] w;
		// column 0 in the top nibble
		for (int c = 0; c < `MAZE_COLS; c++) begin
			w[`ROW_BITS-1-4*c -: 4] = model[r][c];
		end
		return w;
	endfunction

	task automatic check_value(input string name, input int exp, input int got);
		if (exp != got) begin
			$display("FAILED at %0t ns: %s expected %0d, got %0d", $time, name, exp, got);
			value_errors++;
		end
	endtask

	// address on a falling edge, data is back one cycle later
	task automatic compare_row(input int r);
		logic [`ROW_BITS-1:0] exp;
		row_addr = 5'(r);
		tick();
		exp = expected_row(r);
		if (row_data.raw !== exp) begin
			$display("FAILED at %0t ns: row_data[%0d] expected %h, got %h", $time, r, exp,
				row_data.raw);
			value_errors++;
		end
	endtask

	task automatic compare_maze();
		for (int r = 0; r < `MAZE_ROWS; r++) begin
			compare_row(r);
		end
	endtask

	task automatic check_outputs(input int x, input int y, input int p, input logic pl,
		input logic w);
		check_value("pac_pos.x", x, pac_pos.x);
		check_value("pac_pos.y", y, pac_pos.y);
		check_value("pills_left", p, pills_left);
		check_value("playing", pl, playing);
		check_value("won", w, won);
	endtask

	function automatic logic [3:0] one_hot_dir(input logic [3:0] keys);
		logic [3:0] pressed;
		pressed = ~keys;
		if (pressed[3]) return 4'b1000;
		if (pressed[2]) return 4'b0100;
		if (pressed[1]) return 4'b0010;
		return 4'b0001;
	endfunction

	initial begin
		int total_steps;
		int last_chk;
		int chk;
		int key_until;
		int prev_y;
		phase_t ph;
		game_reset = 1'b1;
		key = 4'hf;
		start = 1'b0;
		row_addr = '0;
		cyc = 0;
		value_errors = 0;
		other_errors = 0;
		last_chk = 0;
		key_until = 0;

		set_phase(0, 4'b1110, 1'b0, 1'b0, 2, 20, 15, 37, 1'b0, 1'b0);
		set_phase(1, 4'hf, 1'b1, 1'b0, 18, 38, 15, 19, 1'b1, 1'b0);
		set_phase(2, 4'hf, 1'b1, 1'b0, 1, 38, 15, 19, 1'b1, 1'b0);
		set_phase(3, 4'b0111, 1'b1, 1'b0, 1, 38, 14, 19, 1'b1, 1'b0);
		set_phase(4, 4'b1011, 1'b1, 1'b0, 1, 38, 15, 19, 1'b1, 1'b0);
		set_phase(5, 4'b1101, 1'b1, 1'b0, 37, 1, 15, 0, 1'b0, 1'b1);
		set_phase(6, 4'hf, 1'b1, 1'b0, 2, 1, 15, 0, 1'b0, 1'b1);
		set_phase(7, 4'hf, 1'b0, 1'b1, 5, 20, 15, 37, 1'b0, 1'b0);

		total_steps = 0;
		for (int i = 0; i < NUM_PHASES; i++) begin
			total_steps += phases[i].steps;
		end
		// steps, two fills, full maze scans, margin
		cycle_limit = total_steps * TICKS + 2 * FILL_WAIT + 5 * `MAZE_ROWS + 100;

		model_reset();
		repeat (3) tick();
		game_reset = 1'b0;
		repeat (FILL_WAIT) tick();
		check_outputs(`START_X, `START_Y, `INIT_PILLS, 1'b0, 1'b0);
		compare_maze();

		for (int i = 0; i < NUM_PHASES; i++) begin
			ph = phases[i];
			prev_y = my;
			if (ph.rst) begin
				start = 1'b0;
				key = 4'hf;
				game_reset = 1'b1;
				repeat (3) tick();
				game_reset = 1'b0;
				model_reset();
				repeat (ph.steps * TICKS + 8) tick();
			end else begin
				start = ph.start;
				if (ph.keys != 4'hf) begin
					mdir = one_hot_dir(ph.keys);
					if (!model_playing) begin
						key = ph.keys;
						key_until = cyc + 4;
					end
				end
				// after a win the game stays in won even with start held
				if (ph.start && !model_playing && mpills != 0) begin
					// checkpoints sit one cycle after each move's step pulse
					for (int t = 0; t < 20 && !playing; t++) begin
						tick();
					end
					if (!playing) begin
						$display("playing did not rise after start in phase %0d", i);
						other_errors++;
					end
					model_playing = 1'b1;
					chk = cyc + ph.steps * TICKS + TICKS;
				end else if (model_playing) begin
					chk = last_chk + ph.steps * TICKS;
				end else begin
					chk = cyc + ph.steps * TICKS;
				end
				while (cyc < chk) begin
					tick();
					if (cyc >= key_until) key = 4'hf;
					// the step at the checkpoint opens the next window, so its key
					// has to pass the synchronizer before then
					if (model_playing && cyc == chk - 5 && i + 1 < NUM_PHASES) begin
						if (!phases[i + 1].rst && phases[i + 1].keys != 4'hf) begin
							key = phases[i + 1].keys;
							key_until = cyc + 4;
						end
					end
				end
				last_chk = chk;
				if (model_playing) begin
					repeat (ph.steps) model_step();
					if (mpills == 0) model_playing = 1'b0;
				end
			end
			check_outputs(ph.ex, ph.ey, ph.pills, ph.playing, ph.won);
			if (ph.playing) begin
				compare_row(my);
				compare_row(prev_y);
			end else begin
				compare_maze();
			end
		end

		$display("errors: %0d value mismatches, %0d other failures", value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// watchdog
	initial begin
		wd_cycles = 0;
		@(posedge CLOCK_50);
		while (wd_cycles < cycle_limit) begin
			@(posedge CLOCK_50);
			wd_cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", cycle_limit);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: flist.f
+incdir+include
hdl/pacman_pkg.sv
hdl/key_filter.sv
hdl/move_timer.sv
hdl/game_fsm.sv
hdl/maze_ram.sv
hdl/maze_writer.sv
hdl/pacman_mover.sv
hdl/pacman_game.sv
bench/pacman_game_tb.sv

// File: hdl/game_fsm.sv
`timescale 1ns/100ps

module game_fsm (
	input  logic        CLOCK_50,
	input  logic        game_reset,
	input  logic        start,
	input  logic        fill_done,
	input  logic [10:0] pills_left,
	output logic        fill,
	output logic        play,
	output logic        won
);

	typedef enum logic [1:0] {
		st_fill,
		st_ready,
		st_play,
		st_won
	} state_t;

	state_t state;
	state_t next;

	always_comb begin
		next = state;
		case (state)
			st_fill: begin
				if (fill_done) begin
					next = st_ready;
				end
			end
			st_ready: begin
				if (start) begin
					next = st_play;
				end
			end
			// last pill gone
			st_play: begin
				if (pills_left == '0) begin
					next = st_won;
				end
			end
			default: next = st_won;
		endcase
	end

	always_ff @(posedge CLOCK_50) begin
		if (game_reset) begin
			state <= st_fill;
		end else begin
			state <= next;
		end
	end

	assign fill = (state == st_fill);
	assign play = (state == st_play);
	assign won = (state == st_won);

	play_won_excl: assert property (@(posedge CLOCK_50) !(play && won));

endmodule

// File: hdl/key_filter.sv
`timescale 1ns/100ps

module key_filter (
	input  logic             CLOCK_50,
	input  logic             game_reset,
	input  logic [3:0]       key,
	output pacman_pkg::dir_t dir
);

	// pressed-high after the inversion at the first flop
	logic [3:0] key_meta;
	logic [3:0] key_sync;
	logic [3:0] key_prev;
	logic [3:0] key_rise;

	assign key_rise = key_sync & ~key_prev;

	always_ff @(posedge CLOCK_50) begin
		if (game_reset) begin
			key_meta <= '0;
			key_sync <= '0;
			key_prev <= '0;
			dir <= '0;
		end else begin
			key_meta <= ~key;
			key_sync <= key_meta;
			key_prev <= key_sync;
			// new press wins, priority up, down, left, right
			if (key_rise[3]) begin
				dir <= '{up: 1'b1, down: 1'b0, left: 1'b0, right: 1'b0};
			end else if (key_rise[2]) begin
				dir <= '{up: 1'b0, down: 1'b1, left: 1'b0, right: 1'b0};
			end else if (key_rise[1]) begin
				dir <= '{up: 1'b0, down: 1'b0, left: 1'b1, right: 1'b0};
			end else if (key_rise[0]) begin
				dir <= '{up: 1'b0, down: 1'b0, left: 1'b0, right: 1'b1};
			end
			// otherwise keep the last direction so pac-man keeps going
		end
	end

endmodule

// File: hdl/maze_ram.sv
`timescale 1ns/100ps
`include "pacman_params.svh"

module maze_ram (
	input  logic                  CLOCK_50,
	input  logic [4:0]            addr_a,
	output pacman_pkg::maze_row_u q_a,
	input  logic [4:0]            addr_b,
	input  pacman_pkg::maze_row_u data_b,
	input  logic                  wren_b,
	output pacman_pkg::maze_row_u q_b
);

	pacman_pkg::maze_row_u mem [0:`MAZE_ROWS-1];

	// port a, display scan
	always_ff @(posedge CLOCK_50) begin
		q_a <= mem[addr_a];
	end

	// port b, read old data on a write to the same row
	always_ff @(posedge CLOCK_50) begin
		if (wren_b) begin
			mem[addr_b] <= data_b;
		end
		q_b <= mem[addr_b];
	end

	addr_b_range: assert property (@(posedge CLOCK_50) wren_b |-> addr_b < `MAZE_ROWS);

endmodule

// File: hdl/maze_writer.sv
`timescale 1ns/100ps
`include "pacman_params.svh"

module maze_writer (
	input  logic                  CLOCK_50,
	input  logic                  game_reset,
	input  logic                  fill,
	output logic                  fill_done,
	input  logic                  req_valid,
	input  pacman_pkg::move_req_t req,
	output logic                  done,
	output logic                  moved,
	output logic [10:0]           pills_left,
	output logic [4:0]            ram_addr,
	output pacman_pkg::maze_row_u ram_wdata,
	output logic                  ram_wren,
	input  pacman_pkg::maze_row_u ram_q
);

	typedef enum logic [2:0] {
		s_idle,
		s_check,
		s_rd_cur,
		s_wr_cur,
		s_finish
	} state_t;

	state_t state;
	pacman_pkg::move_req_t cur_req;
	logic [4:0] fill_row;
	logic filled;
	logic ate_pill;
	pacman_pkg::tile_t tgt_tile;

	// fresh maze: border walls, pill corridor on the start row, pac-man on his tile
	function automatic pacman_pkg::maze_row_u fill_row_word(input logic [4:0] r);
		pacman_pkg::maze_row_u w;
		for (int c = 0; c < `MAZE_COLS; c++) begin
			if (r == 5'd0 || r == 5'(`MAZE_ROWS - 1) || c == 0 || c == `MAZE_COLS - 1) begin
				w.tiles[c] = pacman_pkg::wall;
			end else if (r == 5'(`START_Y) && c == `START_X) begin
				w.tiles[c] = pacman_pkg::pacman;
			end else if (r == 5'(`START_Y)) begin
				w.tiles[c] = pacman_pkg::pill;
			end else begin
				w.tiles[c] = pacman_pkg::empty;
			end
		end
		return w;
	endfunction

	// target row is on ram_q while in s_check
	assign tgt_tile = ram_q.tiles[cur_req.tgt.x];

	always_comb begin
		ram_addr = cur_req.tgt.y;
		ram_wdata = ram_q;
		ram_wren = 1'b0;
		if (fill && !filled) begin
			ram_addr = fill_row;
			ram_wdata = fill_row_word(fill_row);
			ram_wren = 1'b1;
		end else begin
			case (state)
				// start the target row read as the request arrives
				s_idle: ram_addr = req.tgt.y;
				s_check: begin
					ram_wdata.tiles[cur_req.tgt.x] = pacman_pkg::pacman;
					ram_wren = (tgt_tile != pacman_pkg::wall);
				end
				s_rd_cur: ram_addr = cur_req.cur.y;
				s_wr_cur: begin
					ram_addr = cur_req.cur.y;
					ram_wdata.tiles[cur_req.cur.x] = pacman_pkg::empty;
					ram_wren = 1'b1;
				end
				default: ram_wren = 1'b0;
			endcase
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (state == s_idle && req_valid) begin
			cur_req <= req;
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (game_reset) begin
			state <= s_idle;
			fill_row <= '0;
			filled <= 1'b0;
			fill_done <= 1'b0;
			done <= 1'b0;
			moved <= 1'b0;
			ate_pill <= 1'b0;
			pills_left <= '0;
		end else begin
			fill_done <= 1'b0;
			done <= 1'b0;
			moved <= 1'b0;
			if (fill && !filled) begin
				fill_row <= fill_row + 5'd1;
				pills_left <= 11'(`INIT_PILLS);
				if (fill_row == 5'(`MAZE_ROWS - 1)) begin
					filled <= 1'b1;
					fill_done <= 1'b1;
				end
			end
			case (state)
				s_idle: begin
					if (req_valid) begin
						state <= s_check;
					end
				end
				s_check: begin
					ate_pill <= (tgt_tile == pacman_pkg::pill);
					if (tgt_tile == pacman_pkg::wall) begin
						// blocked, report back at once
						done <= 1'b1;
						state <= s_idle;
					end else begin
						state <= s_rd_cur;
					end
				end
				s_rd_cur: state <= s_wr_cur;
				s_wr_cur: state <= s_finish;
				default: begin
					done <= 1'b1;
					moved <= 1'b1;
					if (ate_pill) begin
						pills_left <= pills_left - 11'd1;
					end
					state <= s_idle;
				end
			endcase
		end
	end

	// the move timer period keeps requests apart
	req_when_idle: assert property (@(posedge CLOCK_50) disable iff (game_reset)
		req_valid |-> (state == s_idle && filled));

endmodule

// File: hdl/move_timer.sv
`timescale 1ns/100ps
`include "pacman_params.svh"

module move_timer #(
	parameter int TICKS = `MOVE_TICKS
) (
	input  logic CLOCK_50,
	input  logic game_reset,
	input  logic play,
	output logic step
);

	localparam int CW = $clog2(TICKS + 1);

	logic [CW-1:0] count;

	always_ff @(posedge CLOCK_50) begin
		if (game_reset || !play) begin
			count <= CW'(TICKS - 1);
			step <= 1'b0;
		end else if (count == '0) begin
			count <= CW'(TICKS - 1);
			step <= 1'b1;
		end else begin
			count <= count - 1'b1;
			step <= 1'b0;
		end
	end

	// a move takes 6 cycles from step to done, the next step must come later
	ticks_min: assert property (@(posedge CLOCK_50) TICKS >= 8);

endmodule

// File: hdl/pacman_game.sv
`timescale 1ns/100ps
`include "pacman_params.svh"

module pacman_game #(
	parameter int TICKS = `MOVE_TICKS
) (
	input  logic                  CLOCK_50,
	input  logic                  game_reset,
	input  logic [3:0]            key,
	input  logic                  start,
	input  logic [4:0]            row_addr,
	output pacman_pkg::maze_row_u row_data,
	output pacman_pkg::coord_t    pac_pos,
	output logic [10:0]           pills_left,
	output logic                  playing,
	output logic                  won
);

	pacman_pkg::dir_t dir;
	pacman_pkg::move_req_t req;
	pacman_pkg::maze_row_u ram_wdata;
	pacman_pkg::maze_row_u ram_q;
	logic [4:0] ram_addr;
	logic ram_wren;
	logic fill;
	logic fill_done;
	logic step;
	logic req_valid;
	logic done;
	logic moved;

	key_filter key_filter_i (.CLOCK_50(CLOCK_50), .game_reset(game_reset), .key(key), .dir(dir));

	// playing doubles as the timer enable
	move_timer #(.TICKS(TICKS)) move_timer_i (.CLOCK_50(CLOCK_50), .game_reset(game_reset),
		.play(playing), .step(step));

	game_fsm game_fsm_i (.CLOCK_50(CLOCK_50), .game_reset(game_reset), .start(start),
		.fill_done(fill_done), .pills_left(pills_left), .fill(fill), .play(playing),
		.won(won));

	// port a scans for the display, port b belongs to the writer
	maze_ram maze_ram_i (.CLOCK_50(CLOCK_50), .addr_a(row_addr), .q_a(row_data),
		.addr_b(ram_addr), .data_b(ram_wdata), .wren_b(ram_wren), .q_b(ram_q));

	maze_writer maze_writer_i (.CLOCK_50(CLOCK_50), .game_reset(game_reset), .fill(fill),
		.fill_done(fill_done), .req_valid(req_valid), .req(req), .done(done), .moved(moved),
		.pills_left(pills_left), .ram_addr(ram_addr), .ram_wdata(ram_wdata),
		.ram_wren(ram_wren), .ram_q(ram_q));

	pacman_mover pacman_mover_i (.CLOCK_50(CLOCK_50), .game_reset(game_reset), .dir(dir),
		.step(step), .req_valid(req_valid), .req(req), .done(done), .moved(moved),
		.pac_pos(pac_pos));

endmodule

// File: hdl/pacman_mover.sv
`timescale 1ns/100ps
`include "pacman_params.svh"

module pacman_mover (
	input  logic                  CLOCK_50,
	input  logic                  game_reset,
	input  pacman_pkg::dir_t      dir,
	input  logic                  step,
	output logic                  req_valid,
	output pacman_pkg::move_req_t req,
	input  logic                  done,
	input  logic                  moved,
	output pacman_pkg::coord_t    pac_pos
);

	pacman_pkg::coord_t target;
	logic any_dir;

	assign any_dir = (dir != '0);

	// neighbour tile, border walls keep it in range
	always_comb begin
		target = pac_pos;
		if (dir.up) begin
			target.y = pac_pos.y - 5'd1;
		end else if (dir.down) begin
			target.y = pac_pos.y + 5'd1;
		end else if (dir.left) begin
			target.x = pac_pos.x - 6'd1;
		end else if (dir.right) begin
			target.x = pac_pos.x + 6'd1;
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (step) begin
			req <= '{cur: pac_pos, tgt: target};
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (game_reset) begin
			req_valid <= 1'b0;
			pac_pos <= '{x: 6'(`START_X), y: 5'(`START_Y)};
		end else begin
			req_valid <= step && any_dir;
			if (done && moved) begin
				pac_pos <= req.tgt;
			end
		end
	end

	// position must not drift while the writer works on a move
	pos_stable: assert property (@(posedge CLOCK_50) disable iff (game_reset)
		(done && moved) |-> (req.cur == pac_pos));

endmodule

// File: hdl/pacman_pkg.sv
`include "pacman_params.svh"

package pacman_pkg;

	// tile codes as held in the maze ram
	typedef enum logic [`TILE_BITS-1:0] {
		empty,
		wall,
		pill,
		pacman
	} tile_t;

	// tile position, x is the column and y the row
	typedef struct packed {
		logic [5:0] x;
		logic [4:0] y;
	} coord_t;

	// one maze row, either the raw ram word or its tiles
	// ascending range puts column 0 in the top bits (left-right flip)
	typedef union packed {
		logic [`ROW_BITS-1:0] raw;
		tile_t [0:`MAZE_COLS-1] tiles;
	} maze_row_u;

	// one move from the current tile to a neighbour
	typedef struct packed {
		coord_t cur;
		coord_t tgt;
	} move_req_t;

	// one-hot direction
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
	} dir_t;

endpackage

// File: include/pacman_params.svh
`ifndef PACMAN_PARAMS_SVH
`define PACMAN_PARAMS_SVH

// maze geometry in tiles
`define MAZE_COLS 40
`define MAZE_ROWS 30

// one tile code, and one full row as the ram stores it
`define TILE_BITS 4
`define ROW_BITS 160

// pac-man start tile
`define START_X 20
`define START_Y 15

// interior of the start row minus the start tile
`define INIT_PILLS 37

// clock cycles between two moves, must stay at 8 or more
`define MOVE_TICKS 16

`endif

// File: run_sim.sh
#!/bin/sh
# compile and run the pacman_game testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module pacman_game_tb -f flist.f -o pacman_sim

./obj_dir/pacman_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
	exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
	exit 1
fi
exit 0
